// File: verilog.f
+incdir+common
common/spi_pkg.sv
common/xfer_pkg.sv
design/xfer_fifo.sv
spi_master/spi_shifter.sv
spi_master/spi_sequencer.sv
design/spi_bridge_top.sv
sim/spi_slave_model.sv
sim/tb_spi_bridge.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timescale 1ns/1ns -f verilog.f --top-module tb_spi_bridge \
    -o sim_spi_bridge &&
./obj_dir/sim_spi_bridge ||
exit 1

// File: sim/tb_spi_bridge.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module tb_spi_bridge import spi_pkg::*, xfer_pkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam int CMD_CYCLES = 16 * `SPI_DIV_HALF + `SPI_CS_SETUP + `SPI_CS_GAP + 4;
    localparam int TOTAL_CMDS = 1 + 3 + `CMD_DEPTH + (`CMD_DEPTH + 3) + 20;
    localparam int WATCHDOG_CYCLES = 4 * TOTAL_CMDS * CMD_CYCLES;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    xfer_cmd_t   cmd;
    logic        cmd_drop;
    logic        rsp_valid;
    xfer_rsp_t   rsp;
    logic        busy;
    logic        miso;
    spi_pins_t   pins;
    logic [7:0]  slave_last;
    logic [31:0] slave_frames;

    // Accepted commands still waiting for their response
    xfer_cmd_t   sent_q[$];
    xfer_rsp_t   rsp_q[$];
    logic [7:0]  slave_q[$];
    logic [7:0]  prev_byte;
    logic [3:0]  next_tag;

    spi_bridge_top u_spi_bridge_top (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_drop  (cmd_drop),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy),
        .miso      (miso),
        .pins      (pins)
    );

    spi_slave_model u_spi_slave_model (
        .rst         (rst),
        .pins        (pins),
        .miso        (miso),
        .last_rx     (slave_last),
        .frame_count (slave_frames)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Response monitor that also records what the slave got for that byte
    always @(negedge clk) begin
        if (!rst && rsp_valid) begin
            rsp_q.push_back(rsp);
            slave_q.push_back(slave_last);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            abort_run("A checked value did not match");
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic push_cmd(input logic [7:0] data, input logic hold, output logic dropped);
        xfer_cmd_t c;
        c.data = data;
        c.tag  = next_tag;
        c.hold = hold;
        cmd_valid = 1'b1;
        cmd       = c;
        #(CLK_PERIOD / 4);
        dropped = cmd_drop;
        if (!dropped) begin
            sent_q.push_back(c);
        end
        next_tag = next_tag + 4'd1;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // Waits for n responses, and for busy to drop when idle is set
    task automatic wait_rsp(input int n, input logic idle);
        int cycles;
        cycles = 0;
        while (rsp_q.size() < n || (idle && busy)) begin
            if (cycles >= 2 * (n + 1) * CMD_CYCLES) begin
                abort_run("Timeout: responses or idle state did not arrive in time");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Each reply carries the byte the slave received before
    task automatic compare_responses();
        xfer_cmd_t  c;
        xfer_rsp_t  r;
        logic [7:0] s;
        while (sent_q.size() > 0 && rsp_q.size() > 0) begin
            c = sent_q.pop_front();
            r = rsp_q.pop_front();
            s = slave_q.pop_front();
            check("rsp.data", 32'(r.data), 32'(prev_byte));
            check("rsp.tag", 32'(r.tag), 32'(c.tag));
            check("rsp.last", 32'(r.last), 32'(!c.hold));
            check("slave rx byte", 32'(s), 32'(c.data));
            prev_byte = c.data;
        end
        check("extra responses", 32'(rsp_q.size()), 32'd0);
    endtask

    task automatic reset_values();
        repeat (4) begin
            check("pins.cs_n", 32'(pins.cs_n), 32'd1);
            check("pins.sck", 32'(pins.sck), 32'd0);
            check("rsp_valid", 32'(rsp_valid), 32'd0);
            check("cmd_drop", 32'(cmd_drop), 32'd0);
            check("busy", 32'(busy), 32'd0);
            @(negedge clk);
        end
    endtask

    task automatic single_echo();
        logic [31:0] frames;
        logic        dropped;
        frames = slave_frames;
        push_cmd(8'hA5, 1'b0, dropped);
        check("cmd_drop", 32'(dropped), 32'd0);
        wait_rsp(1, 1'b1);
        compare_responses();
        check("frame count", slave_frames, frames + 32'd1);
    endtask

    task automatic held_frame();
        logic [31:0] frames;
        logic        dropped;
        frames = slave_frames;
        push_cmd(8'h3C, 1'b1, dropped);
        check("cmd_drop", 32'(dropped), 32'd0);
        wait_rsp(1, 1'b0);
        // Host pause inside the frame
        repeat (5) @(negedge clk);
        check("pins.cs_n", 32'(pins.cs_n), 32'd0);
        push_cmd(8'hC3, 1'b1, dropped);
        check("cmd_drop", 32'(dropped), 32'd0);
        push_cmd(8'h5A, 1'b0, dropped);
        check("cmd_drop", 32'(dropped), 32'd0);
        wait_rsp(3, 1'b1);
        compare_responses();
        check("frame count", slave_frames, frames + 32'd1);
    endtask

    task automatic queued_burst();
        logic dropped;
        for (int i = 0; i < `CMD_DEPTH; i++) begin
            push_cmd(8'($urandom), 1'b0, dropped);
            check("cmd_drop", 32'(dropped), 32'd0);
        end
        wait_rsp(`CMD_DEPTH, 1'b1);
        compare_responses();
    endtask

    task automatic queue_overflow();
        int   drops;
        logic dropped;
        drops = 0;
        for (int i = 0; i < `CMD_DEPTH + 3; i++) begin
            push_cmd(8'($urandom), 1'b0, dropped);
            if (dropped) begin
                drops++;
            end
        end
        check("drops seen", 32'(drops > 0), 32'd1);
        wait_rsp(sent_q.size(), 1'b1);
        check("responses plus drops", 32'(rsp_q.size() + drops), 32'(`CMD_DEPTH + 3));
        compare_responses();
    endtask

    task automatic random_traffic();
        logic [31:0] frames;
        logic        hold;
        logic        dropped;
        int          ends;
        frames = slave_frames;
        ends = 0;
        for (int i = 0; i < 20; i++) begin
            hold = (i == 19) ? 1'b0 : 1'($urandom % 2);
            if (!hold) begin
                ends++;
            end
            push_cmd(8'($urandom), hold, dropped);
            check("cmd_drop", 32'(dropped), 32'd0);
            wait_rsp(1, !hold);
            compare_responses();
            repeat (int'($urandom % 4)) @(negedge clk);
        end
        check("frame count", slave_frames, frames + 32'(ends));
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Timeout: watchdog expired before the tests finished");
    end

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        prev_byte = 8'h00;
        next_tag  = 4'd0;
        void'($urandom(32'h34db6811));
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        single_echo();
        held_frame();
        queued_burst();
        queue_overflow();
        random_traffic();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: sim/spi_slave_model.sv
`timescale 1ns/1ns

module spi_slave_model import spi_pkg::*; (
    input  logic        rst,
    input  spi_pins_t   pins,
    output logic        miso,
    output logic [7:0]  last_rx,
    output logic [31:0] frame_count
);

    logic       sck;
    logic       cs_n;
    logic [7:0] tx_sr;
    logic [7:0] rx_sr;
    logic [2:0] bit_cnt;

    assign sck  = pins.sck;
    assign cs_n = pins.cs_n;

    // Drive side, MSB first
    // Each byte starts from the last byte received
    always_ff @(posedge sck or posedge rst) begin
        if (rst) begin
            miso  <= 1'b0;
            tx_sr <= '0;
        end else if (!cs_n) begin
            if (bit_cnt == 3'd0) begin
                miso  <= last_rx[7];
                tx_sr <= {last_rx[6:0], 1'b0};
            end else begin
                miso  <= tx_sr[7];
                tx_sr <= {tx_sr[6:0], 1'b0};
            end
        end
    end

    // MOSI sampled on the trailing edge
    always_ff @(negedge sck or posedge rst) begin
        if (rst) begin
            rx_sr   <= '0;
            bit_cnt <= '0;
            last_rx <= 8'h00;
        end else if (!cs_n) begin
            rx_sr   <= {rx_sr[6:0], pins.mosi};
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) begin
                last_rx <= {rx_sr[6:0], pins.mosi};
            end
        end
    end

    // One frame per chip-select release
    always_ff @(posedge cs_n or posedge rst) begin
        if (rst) begin
            frame_count <= '0;
        end else begin
            frame_count <= frame_count + 32'd1;
        end
    end

endmodule

// File: design/spi_bridge_top.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_bridge_top import spi_pkg::*, xfer_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_valid,
    input  xfer_cmd_t cmd,
    output logic      cmd_drop,
    output logic      rsp_valid,
    output xfer_rsp_t rsp,
    output logic      busy,
    input  logic      miso,
    output spi_pins_t pins
);

    xfer_cmd_t  fifo_head;
    logic       fifo_empty;
    logic       seq_pop;
    logic       seq_start;
    logic [7:0] seq_tx_data;
    logic       seq_cs_n;
    logic       shift_busy;
    logic       shift_done;
    logic [7:0] shift_rx_data;
    logic       shift_sck;
    logic       shift_mosi;

    // Command queue, the host never stalls
    xfer_fifo #(
        .DEPTH (`CMD_DEPTH)
    ) u_xfer_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_valid),
        .push_data (cmd),
        .pop       (seq_pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (),
        .drop      (cmd_drop)
    );

    spi_sequencer u_spi_sequencer (
        .clk        (clk),
        .rst        (rst),
        .empty      (fifo_empty),
        .head       (fifo_head),
        .pop        (seq_pop),
        .shift_busy (shift_busy),
        .shift_done (shift_done),
        .rx_data    (shift_rx_data),
        .start      (seq_start),
        .tx_data    (seq_tx_data),
        .cs_n       (seq_cs_n),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .busy       (busy)
    );

    spi_shifter u_spi_shifter (
        .clk     (clk),
        .rst     (rst),
        .start   (seq_start),
        .tx_data (seq_tx_data),
        .miso    (miso),
        .sck     (shift_sck),
        .mosi    (shift_mosi),
        .busy    (shift_busy),
        .done    (shift_done),
        .rx_data (shift_rx_data)
    );

    assign pins.sck  = shift_sck;
    assign pins.mosi = shift_mosi;
    assign pins.cs_n = seq_cs_n;

endmodule

// File: spi_master/spi_sequencer.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_sequencer import xfer_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       empty,
    input  xfer_cmd_t  head,
    output logic       pop,
    input  logic       shift_busy,
    input  logic       shift_done,
    input  logic [7:0] rx_data,
    output logic       start,
    output logic [7:0] tx_data,
    output logic       cs_n,
    output logic       rsp_valid,
    output xfer_rsp_t  rsp,
    output logic       busy
);

    localparam int CNT_MAX = (`SPI_CS_GAP > `SPI_CS_SETUP) ? `SPI_CS_GAP : `SPI_CS_SETUP;
    localparam int CNT_W = $clog2(CNT_MAX + 1);
    localparam logic [CNT_W-1:0] SETUP_CNT = CNT_W'(`SPI_CS_SETUP);
    localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(`SPI_CS_GAP - 1);

    typedef enum logic [2:0] {
        seq_idle,
        seq_setup,
        seq_shift,
        seq_resp,
        seq_hold,
        seq_gap
    } seq_state_t;

    seq_state_t       state;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       cur_tag;
    logic             cur_hold;
    logic             launch;

    // Byte launch after setup time, or straight away inside a held frame
    assign launch = !empty && !shift_busy &&
                    ((state == seq_setup && cnt == SETUP_CNT) || state == seq_hold);

    assign start   = launch;
    assign pop     = launch;
    assign tx_data = head.data;
    assign busy    = !empty || !cs_n;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= seq_idle;
            cnt       <= '0;
            cs_n      <= 1'b1;
            cur_hold  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            if (launch) begin
                cur_hold <= head.hold;
            end
            case (state)
                seq_idle: begin
                    if (!empty) begin
                        state <= seq_setup;
                        cs_n  <= 1'b0;
                        cnt   <= '0;
                    end
                end
                seq_setup: begin
                    if (launch) begin
                        state <= seq_shift;
                    end else if (cnt != SETUP_CNT) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                seq_shift: begin
                    if (shift_done) begin
                        state     <= seq_resp;
                        rsp_valid <= 1'b1;
                    end
                end
                seq_resp: begin
                    // Keep the frame open or release chip select
                    if (cur_hold) begin
                        state <= seq_hold;
                    end else begin
                        state <= seq_gap;
                        cs_n  <= 1'b1;
                        cnt   <= '0;
                    end
                end
                seq_hold: begin
                    if (launch) begin
                        state <= seq_shift;
                    end
                end
                seq_gap: begin
                    if (cnt == GAP_LAST) begin
                        state <= seq_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= seq_idle;
                end
            endcase
        end
    end

    // Tag of the byte in flight
    always_ff @(posedge clk) begin
        if (launch) begin
            cur_tag <= head.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == seq_shift && shift_done) begin
            rsp.data <= rx_data;
            rsp.tag  <= cur_tag;
            rsp.last <= ~cur_hold;
        end
    end

endmodule

// File: spi_master/spi_shifter.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module spi_shifter import spi_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] tx_data,
    input  logic       miso,
    output logic       sck,
    output logic       mosi,
    output logic       busy,
    output logic       done,
    output logic [7:0] rx_data
);

    localparam int DIV_W = (`SPI_DIV_HALF > 1) ? $clog2(`SPI_DIV_HALF) : 1;
    localparam int BIT_W = (`SPI_BITS > 1) ? $clog2(`SPI_BITS) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_DIV_HALF - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`SPI_BITS - 1);

    shift_state_t         state;
    shift_state_t         state_nxt;
    logic [DIV_W-1:0]     div_cnt;
    logic [BIT_W-1:0]     bit_cnt;
    logic [`SPI_BITS-1:0] tx_sr;
    logic [`SPI_BITS-1:0] rx_sr;
    logic                 half_end;
    logic                 rise;
    logic                 fall;

    // Last clock of the current half period
    assign half_end = (div_cnt == DIV_LAST);

    // SCK edges land on the clock that ends a half period
    assign rise = (state == sh_lead) && half_end;
    assign fall = (state == sh_trail) && half_end;

    always_comb begin
        state_nxt = state;
        case (state)
            sh_idle: begin
                if (start) begin
                    state_nxt = sh_lead;
                end
            end
            sh_lead: begin
                if (half_end) begin
                    state_nxt = sh_trail;
                end
            end
            sh_trail: begin
                if (half_end) begin
                    state_nxt = (bit_cnt == BIT_LAST) ? sh_done : sh_lead;
                end
            end
            sh_done: begin
                state_nxt = sh_idle;
            end
            default: begin
                state_nxt = sh_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= sh_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Half-period divider, runs only during a byte
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if ((state == sh_lead || state == sh_trail) && !half_end) begin
            div_cnt <= div_cnt + 1'b1;
        end else begin
            div_cnt <= '0;
        end
    end

    // Counts completed SCK periods
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (state == sh_idle) begin
            bit_cnt <= '0;
        end else if (fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Pin registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sck  <= 1'b0;
            mosi <= 1'b0;
        end else if (rise) begin
            sck  <= 1'b1;
            mosi <= tx_sr[`SPI_BITS-1];
        end else if (fall) begin
            sck <= 1'b0;
        end
    end

    // MSB leaves first on each rising edge
    always_ff @(posedge clk) begin
        if (state == sh_idle && start) begin
            tx_sr <= tx_data;
        end else if (rise) begin
            tx_sr <= {tx_sr[`SPI_BITS-2:0], 1'b0};
        end
    end

    // MISO sampled on the trailing edge
    always_ff @(posedge clk) begin
        if (fall) begin
            rx_sr <= {rx_sr[`SPI_BITS-2:0], miso};
        end
    end

    assign busy    = (state != sh_idle);
    assign done    = (state == sh_done);
    assign rx_data = rx_sr;

endmodule

// File: design/xfer_fifo.sv
`timescale 1ns/1ns
`include "spi_consts.svh"

module xfer_fifo import xfer_pkg::*; #(
    parameter int DEPTH = `CMD_DEPTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  xfer_cmd_t push_data,
    input  logic      pop,
    output xfer_cmd_t head,
    output logic      empty,
    output logic      full,
    output logic      drop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

    xfer_cmd_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_LAST) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_FULL);

    // A pop frees the slot for a push in the same cycle
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);
    assign drop    = push && full && !do_pop;

    // Oldest entry, no read latency
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: common/xfer_pkg.sv
package xfer_pkg;

    // Host command for one byte
    // hold keeps chip select low after this byte
    typedef struct packed {
        logic [7:0] data;
        logic [3:0] tag;
        logic       hold;
    } xfer_cmd_t;

    // Response for one finished byte
    // last marks the final byte of a frame
    typedef struct packed {
        logic [7:0] data;
        logic [3:0] tag;
        logic       last;
    } xfer_rsp_t;

endpackage

// File: common/spi_pkg.sv
package spi_pkg;

    // Pins driven toward the slave
    // sck idles low in this mode
    typedef struct packed {
        logic sck;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

    // Byte shifter phases
    // lead is the low half of SCK and trail the high half
    typedef enum logic [1:0] {
        sh_idle,
        sh_lead,
        sh_trail,
        sh_done
    } shift_state_t;

endpackage

// File: common/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// System clocks per half SCK period
`define SPI_DIV_HALF 4

// Bits per transfer
`define SPI_BITS 8

// Clocks from chip-select fall to the byte start
`define SPI_CS_SETUP 2

// Minimum clocks with chip select high between frames
`define SPI_CS_GAP 3

// Default command queue depth
`define CMD_DEPTH 4

`endif
